// File: Bender.yml
package:
  name: c16_mem_bridge

sources:
  - files:
      - src/c16_mem_pkg.sv
      - src/slot_timer.sv
      - src/dram_addr_latch.sv
      - src/inject_fsm.sv
      - src/zp_shadow.sv
      - src/mem_mux.sv
      - src/c16_mem_bridge.sv
  - target: test
    files:
      - dv/tb_c16_mem_bridge.sv

# top modules
#   design:    c16_mem_bridge
#   testbench: tb_c16_mem_bridge

// File: dv/c16_stimulus.txt
// columns: op, argument, byte (hex); 1 group, 2 download start (index), 3 download byte (offset)
// 4 download end, 5 C16 write, 6 C16 read, 7 kernal read, 8 memory byte, 9 16k mode, 0 end
1 1 0
2 01 0
3 0000 01
3 0001 10
3 0002 a9
3 0003 05
3 0004 8d
3 0005 20
4 0 0
8 01001 a9
8 01004 20
6 1002 05
1 2 0
6 002d 06
6 002e 10
6 002f 06
6 0030 10
6 0031 06
6 0032 10
6 009d 06
6 009e 10
1 3 0
5 002f 5c
6 002f 5c
6 0030 10
5 1235 77
6 1235 77
6 1234 40
1 4 0
2 00 0
3 0000 11
3 0001 22
3 4000 c1
3 4001 c2
3 4002 c3
4 0 0
7 0000 c1
7 0001 c2
7 0002 c3
8 10000 c1
2 03 0
3 0000 e1
3 0001 e2
4 0 0
7 0000 e1
7 0001 e2
7 0002 c3
1 5 0
9 1 0
5 c123 3a
6 0123 3a
8 00223 3a
9 0 0
0 0 0

// File: dv/tb_c16_mem_bridge.sv
// -------------------------------------------------
// testbench for the C16 memory bridge, commands from dv/c16_stimulus.txt
// memory model holds the low 64k words, untouched words read a fill pattern
// C16 slot is bus phases 9 to 15 and 0, ras falls at phase 0
// -------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_c16_mem_bridge;
	import c16_mem_pkg::*;

	logic        clk28;
	logic        reset;
	c16_bus_t    c16_bus;
	ioctl_t      ioctl;
	logic        mem_16k;
	logic [15:0] mem_dout;
	mem_req_t    mem_req;
	byte_t       c16_din;
	logic        c16_wait;

	// command list, three entries per command: op, argument, byte
	logic [24:0] stim [0:287];
	logic [15:0] mem_words [0:65535];
	// bus model state and the command it drives next
	logic [3:0]  bus_phase;
	logic        cmd_rw;
	logic        cmd_rom;
	c16_addr_t   cmd_addr;
	byte_t       cmd_dout;
	rom_addr_t   cmd_rom_addr;
	// full address of the bus cycle in flight
	c16_addr_t   bus_addr;
	logic        dl_active;
	integer      seed;
	int          n_cmds;
	int          cycle_cnt;
	int          cycle_limit;
	int          err_cnt;
	int          check_cnt;
	int          grp_num;
	int          grp_checks;
	int          grp_errs;
	int          grp_total;

	c16_mem_bridge dut_i (
		.clk28      (clk28),
		.reset      (reset),
		.c16_bus_i  (c16_bus),
		.ioctl_i    (ioctl),
		.mem_16k_i  (mem_16k),
		.mem_dout_i (mem_dout),
		.mem_req_o  (mem_req),
		.c16_din_o  (c16_din),
		.c16_wait_o (c16_wait)
	);

	always #20 clk28 = ~clk28;

	// -----------------------------------------------
	// C16 bus model, ras falls at phase 0, cas at 4
	// -----------------------------------------------
	always @(posedge clk28) begin
		#2;
		bus_phase = bus_phase + 4'd1;
		case (bus_phase)
			4'd0: begin
				// row byte first, the command holds for the whole cycle
				c16_bus.ras        = 1'b0;
				c16_bus.rw         = cmd_rw;
				c16_bus.a          = cmd_addr[7:0];
				c16_bus.dout       = cmd_dout;
				c16_bus.kernal_sel = ~cmd_rom;
				c16_bus.rom_addr   = cmd_rom_addr;
				bus_addr           = cmd_addr;
			end
			4'd4: begin
				c16_bus.cas = 1'b0;
				c16_bus.a   = cmd_addr[15:8];
			end
			4'd15: begin
				c16_bus.ras = 1'b1;
				c16_bus.cas = 1'b1;
			end
			default: ;
		endcase
	end

	// -----------------------------------------------
	// memory model, combinational read
	// -----------------------------------------------
	assign mem_dout = mem_words[mem_req.addr[15:0]];

	always @(posedge clk28) begin
		if (mem_req.we === 1'b1) begin
			assert (mem_req.addr[23:16] == 8'd0) else begin
				$display("memory write above the modeled 64k words at %0t ns", $time);
				count_error();
			end
			if (mem_req.ds[0])
				mem_words[mem_req.addr[15:0]][7:0] = mem_req.din[7:0];
			if (mem_req.ds[1])
				mem_words[mem_req.addr[15:0]][15:8] = mem_req.din[15:8];
		end
	end

	// C16 slot writes only come from the core at its own address
	// wait stays up while loading
	always @(negedge clk28) begin
		if (!reset && (bus_phase >= 4'd9 || bus_phase == 4'd0) && mem_req.we === 1'b1) begin
			assert (c16_bus.rw == 1'b0) else begin
				$display("injector write reached memory in the C16 slot at %0t ns", $time);
				count_error();
			end
			assert (mem_req.addr == ram_word_addr(bus_addr, mem_16k)) else begin
				$display("Error at %0t ns: mem_req_o.addr = 0x%06h, expected 0x%06h",
					$time, mem_req.addr, ram_word_addr(bus_addr, mem_16k));
				count_error();
			end
		end
		if (dl_active) begin
			assert (c16_wait === 1'b1) else begin
				$display("Error at %0t ns: c16_wait_o = %b, expected 1", $time, c16_wait);
				count_error();
			end
		end
	end

	// watchdog, limit set once the command list is known
	always @(posedge clk28) begin
		cycle_cnt++;
		if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
			$display("timeout after %0d cycles, the command list did not finish", cycle_cnt);
			$display("test failed");
			$finish;
		end
	end

	// -----------------------------------------------
	// helpers
	// -----------------------------------------------
	function automatic logic [15:0] fill_word(input logic [15:0] idx);
		return idx ^ 16'hc35a;
	endfunction

	function automatic byte_t mem_byte(input mem_baddr_t baddr);
		logic [15:0] word;
		word = mem_words[baddr[16:1]];
		return baddr[0] ? word[15:8] : word[7:0];
	endfunction

	// 64k is a plain shift, 16k drops bits 15:14 and has word bit 7 at zero
	function automatic mem_waddr_t ram_word_addr(input c16_addr_t a, input logic m16);
		if (m16)
			return {10'd0, a[13:8], 1'b0, a[7:1]};
		else
			return {9'd0, a[15:1]};
	endfunction

	task automatic count_error();
		err_cnt++;
		grp_errs++;
	endtask

	task automatic check_value(input string name, input byte_t got, input byte_t exp);
		check_cnt++;
		grp_checks++;
		assert (got === exp) else begin
			$display("Error at %0t ns: %s = 0x%02h, expected 0x%02h", $time, name, got, exp);
			count_error();
		end
	endtask

	task automatic close_group();
		if (grp_num > 0) begin
			$display("group %0d: %0d checks, %0d errors", grp_num, grp_checks, grp_errs);
			grp_total++;
		end
		grp_checks = 0;
		grp_errs   = 0;
	endtask

	// phase is stable at the falling edge
	task automatic wait_phase(input logic [3:0] p);
		do
			@(negedge clk28);
		while (bus_phase != p);
	endtask

	// 32 to 47 cycles between download bytes
	task automatic wait_gap();
		int gap;
		gap = 32 + ($random(seed) & 15);
		repeat (gap) @(posedge clk28);
	endtask

	task automatic download_start(input byte_t idx);
		@(posedge clk28);
		#2;
		ioctl.index       = idx;
		ioctl.downloading = 1'b1;
		dl_active         = 1'b1;
		wait_gap();
	endtask

	task automatic download_byte(input mem_baddr_t ofs, input byte_t data);
		@(posedge clk28);
		#2;
		ioctl.addr = ofs;
		ioctl.data = data;
		ioctl.wr   = 1'b1;
		@(posedge clk28);
		#2;
		ioctl.wr = 1'b0;
		wait_gap();
	endtask

	// wait must be down two cycles after downloading falls
	task automatic download_end();
		@(posedge clk28);
		#2;
		ioctl.downloading = 1'b0;
		dl_active         = 1'b0;
		repeat (2) @(posedge clk28);
		@(negedge clk28);
		check_value("c16_wait_o", {7'd0, c16_wait}, 8'd0);
		repeat (4) @(posedge clk28);
	endtask

	// one full bus cycle, read byte taken at phase 12
	// cas is low there, so oe follows rw
	task automatic c16_cycle(input logic rw, input logic rom, input c16_addr_t addr,
			input byte_t dout, output byte_t din);
		wait_phase(4'd15);
		cmd_rw       = rw;
		cmd_rom      = rom;
		cmd_addr     = addr;
		cmd_dout     = dout;
		cmd_rom_addr = addr[13:0];
		wait_phase(4'd12);
		din     = c16_din;
		check_value("mem_req_o.oe", {7'd0, mem_req.oe}, {7'd0, rw});
		cmd_rw  = 1'b1;
		cmd_rom = 1'b0;
	endtask

	task automatic run_command(input logic [3:0] op, input logic [24:0] arg, input byte_t val);
		byte_t got;
		case (op)
			4'h1: begin
				close_group();
				grp_num = int'(arg);
			end
			4'h2: download_start(arg[7:0]);
			4'h3: download_byte(arg, val);
			4'h4: download_end();
			4'h5: c16_cycle(1'b0, 1'b0, arg[15:0], val, got);
			4'h6: begin
				c16_cycle(1'b1, 1'b0, arg[15:0], 8'h00, got);
				check_value($sformatf("c16_din_o @0x%04h", arg[15:0]), got, val);
			end
			4'h7: begin
				c16_cycle(1'b1, 1'b1, arg[15:0], 8'h00, got);
				check_value($sformatf("c16_din_o @kernal 0x%04h", arg[15:0]), got, val);
			end
			4'h8: check_value($sformatf("memory byte @0x%05h", arg), mem_byte(arg), val);
			4'h9: begin
				@(posedge clk28);
				#2;
				mem_16k = arg[0];
			end
			default: begin
				$display("unknown command %h in the stimulus file", op);
				count_error();
			end
		endcase
	endtask

	// -----------------------------------------------
	// main sequence
	// -----------------------------------------------
	initial begin
		clk28              = 1'b0;
		reset              = 1'b1;
		mem_16k            = 1'b0;
		ioctl              = '0;
		c16_bus            = '0;
		c16_bus.ras        = 1'b1;
		c16_bus.cas        = 1'b1;
		c16_bus.rw         = 1'b1;
		c16_bus.basic_sel  = 1'b1;
		c16_bus.kernal_sel = 1'b1;
		bus_phase          = 4'd15;
		cmd_rw             = 1'b1;
		cmd_rom            = 1'b0;
		cmd_addr           = '0;
		cmd_dout           = '0;
		cmd_rom_addr       = '0;
		bus_addr           = '0;
		dl_active          = 1'b0;
		seed               = 69;
		err_cnt            = 0;
		check_cnt          = 0;
		grp_num            = 0;
		grp_total          = 0;
		cycle_limit        = 0;
		for (int i = 0; i < 65536; i++)
			mem_words[i] = fill_word(i[15:0]);
		for (int i = 0; i < $size(stim); i++)
			stim[i] = '0;
		$readmemh("dv/c16_stimulus.txt", stim);
		// op 0 ends the list
		n_cmds = 0;
		while (3 * n_cmds < $size(stim) && stim[3 * n_cmds] != '0)
			n_cmds++;
		cycle_limit = n_cmds * 64 + 200;

		repeat (3) @(posedge clk28);
		#2;
		reset = 1'b0;

		if (n_cmds == 0) begin
			$display("no commands found in dv/c16_stimulus.txt");
			count_error();
		end
		for (int i = 0; i < n_cmds; i++)
			run_command(stim[3 * i][3:0], stim[3 * i + 1], stim[3 * i + 2][7:0]);
		close_group();

		$display("%0d groups, %0d checks, %0d errors", grp_total, check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: src.f
src/c16_mem_pkg.sv
src/slot_timer.sv
src/dram_addr_latch.sv
src/inject_fsm.sv
src/zp_shadow.sv
src/mem_mux.sv
src/c16_mem_bridge.sv
dv/tb_c16_mem_bridge.sv

// File: src/c16_mem_bridge.sv
// -------------------------------------------------
// C16 memory bridge, core bus and io download to one
// shared 16 bit memory with a combinational read path
// -------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module c16_mem_bridge (
	input  logic                  clk28,
	input  logic                  reset,
	input  c16_mem_pkg::c16_bus_t c16_bus_i,
	input  c16_mem_pkg::ioctl_t   ioctl_i,
	input  logic                  mem_16k_i,
	input  logic [15:0]           mem_dout_i,
	output c16_mem_pkg::mem_req_t mem_req_o,
	output c16_mem_pkg::byte_t    c16_din_o,
	output logic                  c16_wait_o
);
	import c16_mem_pkg::*;

	slot_t      slot;
	c16_addr_t  c16_baddr;
	mem_req_t   c16_req;
	mem_req_t   inj_req;
	mem_baddr_t inj_addr;
	logic       rom_access;
	logic       prg_end;
	logic       zp_hit;
	byte_t      zp_ovl;

	slot_timer slot_timer_i (
		.clk28  (clk28),
		.reset  (reset),
		.ras_i  (c16_bus_i.ras),
		.slot_o (slot)
	);

	dram_addr_latch dram_addr_latch_i (
		.clk28        (clk28),
		.reset        (reset),
		.bus_i        (c16_bus_i),
		.mem_16k_i    (mem_16k_i),
		.c16_baddr_o  (c16_baddr),
		.c16_req_o    (c16_req),
		.rom_access_o (rom_access)
	);

	inject_fsm inject_fsm_i (
		.clk28      (clk28),
		.reset      (reset),
		.ioctl_i    (ioctl_i),
		.slot_i     (slot),
		.inj_req_o  (inj_req),
		.inj_addr_o (inj_addr),
		.prg_end_o  (prg_end),
		.c16_wait_o (c16_wait_o)
	);

	zp_shadow zp_shadow_i (
		.clk28        (clk28),
		.reset        (reset),
		.bus_i        (c16_bus_i),
		.c16_baddr_i  (c16_baddr),
		.rom_access_i (rom_access),
		.prg_end_i    (prg_end),
		.end_addr_i   (inj_addr),
		.hit_o        (zp_hit),
		.ovl_o        (zp_ovl)
	);

	mem_mux mem_mux_i (
		.slot_i       (slot),
		.c16_req_i    (c16_req),
		.c16_data_i   (c16_bus_i.dout),
		.inj_req_i    (inj_req),
		.c16_baddr0_i (c16_baddr[0]),
		.hit_i        (zp_hit),
		.ovl_i        (zp_ovl),
		.mem_dout_i   (mem_dout_i),
		.mem_req_o    (mem_req_o),
		.c16_din_o    (c16_din_o)
	);

endmodule

`default_nettype wire

// File: src/c16_mem_pkg.sv
// -------------------------------------------------
// shared types and constants of the C16 memory bridge
// memory is 16 bits wide, byte addresses are 25 bits
// -------------------------------------------------
`default_nettype none

package c16_mem_pkg;

	// widths with a meaning of their own
	typedef logic [7:0]  byte_t;
	typedef logic [15:0] c16_addr_t;
	typedef logic [24:0] mem_baddr_t;
	typedef logic [23:0] mem_waddr_t;
	typedef logic [13:0] rom_addr_t;
	typedef logic [3:0]  slot_cnt_t;

	// ROM images live above the 64k of C16 RAM
	localparam mem_baddr_t ROM_MEM_START = 25'h10000;
	localparam mem_baddr_t KERNAL_OFS    = 25'h4000;

	// io controller download indices
	localparam byte_t IDX_ROM    = 8'h00;
	localparam byte_t IDX_PRG    = 8'h01;
	localparam byte_t IDX_KERNAL = 8'h03;

	// low bytes of the BASIC pointers, high byte follows
	localparam c16_addr_t ZP_2D = 16'h002d;
	localparam c16_addr_t ZP_2F = 16'h002f;
	localparam c16_addr_t ZP_31 = 16'h0031;
	localparam c16_addr_t ZP_9D = 16'h009d;
	localparam byte_t     ZP_MISS = 8'hff;

	// multiplexed DRAM and ROM bus of the core
	typedef struct packed {
		logic      ras;
		logic      cas;
		logic      rw;
		byte_t     a;
		byte_t     dout;
		logic      basic_sel;
		logic      kernal_sel;
		rom_addr_t rom_addr;
		logic [3:0] rom_sel;
	} c16_bus_t;

	typedef struct packed {
		logic       downloading;
		byte_t      index;
		logic       wr;
		mem_baddr_t addr;
		byte_t      data;
	} ioctl_t;

	// one request to the shared memory, ds is {upper, lower}
	typedef struct packed {
		mem_waddr_t  addr;
		logic [15:0] din;
		logic        we;
		logic        oe;
		logic [1:0]  ds;
	} mem_req_t;

	typedef struct packed {
		logic c16_slot;
		logic io_start;
		logic c16_start;
	} slot_t;

	typedef enum logic [2:0] {
		IDLE,
		LOAD_LO,
		LOAD_HI,
		STREAM,
		ROM_SKIP
	} inj_state_e;

endpackage

`default_nettype wire

// File: src/dram_addr_latch.sv
// -------------------------------------------------
// rebuilds the CPU address from the row/column bus
// ROM banks map from ROM_MEM_START, 16k mode folds RAM
// -------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dram_addr_latch (
	input  logic                  clk28,
	input  logic                  reset,
	input  c16_mem_pkg::c16_bus_t bus_i,
	input  logic                  mem_16k_i,
	output c16_mem_pkg::c16_addr_t c16_baddr_o,
	output c16_mem_pkg::mem_req_t  c16_req_o,
	output logic                  rom_access_o
);
	import c16_mem_pkg::*;

	logic      ras_q;
	logic      cas_q;
	byte_t     a_lo_q;
	byte_t     a_hi_q;
	logic [1:0] bank;
	c16_addr_t baddr;

	always_ff @(posedge clk28) begin
		if (reset) begin
			ras_q <= 1'b1;
			cas_q <= 1'b1;
		end else begin
			ras_q <= bus_i.ras;
			cas_q <= bus_i.cas;
		end
	end

	// row byte on falling ras, column byte on falling cas
	always_ff @(posedge clk28) begin
		if (ras_q && !bus_i.ras)
			a_lo_q <= bus_i.a;
		if (cas_q && !bus_i.cas)
			a_hi_q <= bus_i.a;
	end

	assign rom_access_o = (!bus_i.basic_sel || !bus_i.kernal_sel) && bus_i.rw;

	// kernal 0, basic 1, function low 2, function high 3
	// cartridge selects are not mapped and fall back to the kernal
	always_comb begin
		casez ({bus_i.basic_sel, bus_i.rom_sel})
			5'b1_00??: bank = 2'd0;
			5'b1_10??: bank = 2'd3;
			5'b0_??00: bank = 2'd1;
			5'b0_??10: bank = 2'd2;
			default:   bank = 2'd0;
		endcase
	end

	assign baddr       = rom_access_o ? {bank, bus_i.rom_addr} : {a_hi_q, a_lo_q};
	assign c16_baddr_o = baddr;

	always_comb begin
		// rom word base 0x8000 is ROM_MEM_START in byte terms
		if (rom_access_o)
			c16_req_o.addr = {8'd0, 1'b1, bank, bus_i.rom_addr[13:1]};
		else if (mem_16k_i)
			c16_req_o.addr = {9'd0, 1'b0, baddr[13:8], 1'b0, baddr[7:1]};
		else
			c16_req_o.addr = {9'd0, baddr[15:1]};
		// write data lanes are filled in by mem_mux
		c16_req_o.din = '0;
		c16_req_o.we  = !bus_i.cas && !bus_i.rw;
		c16_req_o.oe  = (!bus_i.cas && bus_i.rw) || rom_access_o;
		c16_req_o.ds  = {baddr[0], ~baddr[0]};
	end

endmodule

`default_nettype wire

// File: src/inject_fsm.sv
// -------------------------------------------------
// PRG and ROM download into memory during io slots
// downloading must rise before the first byte strobe
// a byte arriving while one is pending replaces it
// -------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module inject_fsm (
	input  logic                    clk28,
	input  logic                    reset,
	input  c16_mem_pkg::ioctl_t     ioctl_i,
	input  c16_mem_pkg::slot_t      slot_i,
	output c16_mem_pkg::mem_req_t   inj_req_o,
	output c16_mem_pkg::mem_baddr_t inj_addr_o,
	output logic                    prg_end_o,
	output logic                    c16_wait_o
);
	import c16_mem_pkg::*;

	inj_state_e state_q;
	mem_baddr_t addr_q;
	byte_t      data_q;
	byte_t      wdata_q;
	logic       pend_q;
	logic       we_q;
	logic [1:0] prg_dl_q;
	logic       prg_end_q;
	logic       prg_dl;
	logic       rom_dl;

	assign prg_dl = ioctl_i.downloading && (ioctl_i.index == IDX_PRG);
	assign rom_dl = ioctl_i.downloading &&
		((ioctl_i.index == IDX_ROM) || (ioctl_i.index == IDX_KERNAL));

	// core is held for the whole download
	assign c16_wait_o = prg_dl | rom_dl;

	always_ff @(posedge clk28) begin
		if (reset) begin
			state_q   <= IDLE;
			pend_q    <= 1'b0;
			we_q      <= 1'b0;
			prg_dl_q  <= 2'b00;
			prg_end_q <= 1'b0;
		end else begin
			// end of prg download, two cycles after the fall
			prg_dl_q  <= {prg_dl_q[0], prg_dl};
			prg_end_q <= prg_dl_q[1] & ~prg_dl_q[0];

			// io slot starts, pending byte goes out
			if (slot_i.io_start) begin
				we_q    <= pend_q;
				wdata_q <= data_q;
				pend_q  <= 1'b0;
			end
			// C16 slot starts, write is done
			if (slot_i.c16_start && we_q) begin
				we_q   <= 1'b0;
				addr_q <= addr_q + mem_baddr_t'(1);
			end

			case (state_q)
				IDLE: begin
					if (prg_dl) begin
						state_q <= LOAD_LO;
					end else if (rom_dl && ioctl_i.index == IDX_KERNAL) begin
						addr_q  <= ROM_MEM_START;
						state_q <= STREAM;
					end else if (rom_dl) begin
						state_q <= ROM_SKIP;
					end
				end
				// first two prg bytes are the load address
				LOAD_LO: if (ioctl_i.wr) begin
					addr_q[7:0] <= ioctl_i.data;
					state_q     <= LOAD_HI;
				end
				LOAD_HI: if (ioctl_i.wr) begin
					addr_q[24:8] <= {9'd0, ioctl_i.data};
					state_q      <= STREAM;
				end
				// full rom image, skip up to the kernal
				ROM_SKIP: if (ioctl_i.wr && ioctl_i.addr == KERNAL_OFS) begin
					addr_q  <= ROM_MEM_START;
					data_q  <= ioctl_i.data;
					pend_q  <= 1'b1;
					state_q <= STREAM;
				end
				STREAM: if (ioctl_i.wr) begin
					data_q <= ioctl_i.data;
					pend_q <= 1'b1;
				end
				default: state_q <= IDLE;
			endcase

			// leave on end of download, a pending write still finishes
			if (!ioctl_i.downloading)
				state_q <= IDLE;
		end
	end

	assign inj_req_o.addr = addr_q[24:1];
	assign inj_req_o.din  = {wdata_q, wdata_q};
	assign inj_req_o.we   = we_q;
	assign inj_req_o.oe   = 1'b0;
	assign inj_req_o.ds   = {addr_q[0], ~addr_q[0]};
	assign inj_addr_o     = addr_q;
	assign prg_end_o      = prg_end_q;

endmodule

`default_nettype wire

// File: src/mem_mux.sv
// -------------------------------------------------
// shares the memory port between C16 and injector
// read data is valid while the C16 slot is open
// -------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module mem_mux (
	input  c16_mem_pkg::slot_t    slot_i,
	input  c16_mem_pkg::mem_req_t c16_req_i,
	input  c16_mem_pkg::byte_t    c16_data_i,
	input  c16_mem_pkg::mem_req_t inj_req_i,
	input  logic                  c16_baddr0_i,
	input  logic                  hit_i,
	input  c16_mem_pkg::byte_t    ovl_i,
	input  logic [15:0]           mem_dout_i,
	output c16_mem_pkg::mem_req_t mem_req_o,
	output c16_mem_pkg::byte_t    c16_din_o
);

	// C16 owns the high half of the slot, io the low half
	always_comb begin
		if (slot_i.c16_slot) begin
			mem_req_o     = c16_req_i;
			// cpu byte goes on both lanes, ds picks one
			mem_req_o.din = {c16_data_i, c16_data_i};
		end else begin
			mem_req_o = inj_req_i;
		end
	end

	// shadow registers overlay RAM, otherwise pick the byte lane
	always_comb begin
		if (hit_i)
			c16_din_o = ovl_i;
		else if (c16_baddr0_i)
			c16_din_o = mem_dout_i[15:8];
		else
			c16_din_o = mem_dout_i[7:0];
	end

endmodule

`default_nettype wire

// File: src/slot_timer.sv
// -------------------------------------------------
// 16 cycle slot timer locked to the falling RAS
// low half is the io slot, high half the C16 slot
// -------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module slot_timer (
	input  logic               clk28,
	input  logic               reset,
	input  logic               ras_i,
	output c16_mem_pkg::slot_t slot_o
);
	import c16_mem_pkg::*;

	slot_cnt_t cnt_q;
	slot_cnt_t cnt_d;
	logic      ras_q;
	logic      io_start_q;
	logic      c16_start_q;

	// restart on falling ras, free running otherwise
	always_comb begin
		if (ras_q && !ras_i)
			cnt_d = '0;
		else
			cnt_d = cnt_q + slot_cnt_t'(1);
	end

	always_ff @(posedge clk28) begin
		if (reset) begin
			ras_q       <= 1'b1;
			cnt_q       <= '0;
			io_start_q  <= 1'b0;
			c16_start_q <= 1'b0;
		end else begin
			ras_q <= ras_i;
			cnt_q <= cnt_d;
			// pulses line up with the first cycle of the new slot
			io_start_q  <= cnt_q[3] & ~cnt_d[3];
			c16_start_q <= ~cnt_q[3] & cnt_d[3];
		end
	end

	assign slot_o.c16_slot  = cnt_q[3];
	assign slot_o.io_start  = io_start_q;
	assign slot_o.c16_start = c16_start_q;

endmodule

`default_nettype wire

// File: src/zp_shadow.sv
// -------------------------------------------------
// BASIC pointer shadows at 0x2d, 0x2f, 0x31, 0x9d
// contents are undefined until written or loaded
// -------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module zp_shadow (
	input  logic                    clk28,
	input  logic                    reset,
	input  c16_mem_pkg::c16_bus_t   bus_i,
	input  c16_mem_pkg::c16_addr_t  c16_baddr_i,
	input  logic                    rom_access_i,
	input  logic                    prg_end_i,
	input  c16_mem_pkg::mem_baddr_t end_addr_i,
	output logic                    hit_o,
	output c16_mem_pkg::byte_t      ovl_o
);
	import c16_mem_pkg::*;

	logic [15:0] zp_q [4];
	c16_addr_t   zp_base [4];
	logic [3:0]  sel_lo;
	logic [3:0]  sel_hi;
	logic        cas_q;
	logic        wr_stb_q;

	always_comb begin
		zp_base[0] = ZP_2D;
		zp_base[1] = ZP_2F;
		zp_base[2] = ZP_31;
		zp_base[3] = ZP_9D;
		for (int i = 0; i < 4; i++) begin
			sel_lo[i] = (c16_baddr_i == zp_base[i]);
			sel_hi[i] = (c16_baddr_i == zp_base[i] + c16_addr_t'(1));
		end
	end

	// write strobe one cycle after falling cas, address is settled
	always_ff @(posedge clk28) begin
		if (reset) begin
			cas_q    <= 1'b1;
			wr_stb_q <= 1'b0;
		end else begin
			cas_q    <= bus_i.cas;
			wr_stb_q <= !bus_i.cas && cas_q;
		end
	end

	// end of prg load wins over a cpu write
	always_ff @(posedge clk28) begin
		for (int i = 0; i < 4; i++) begin
			if (prg_end_i) begin
				zp_q[i] <= end_addr_i[15:0] + 16'd1;
			end else if (wr_stb_q && !bus_i.rw) begin
				if (sel_lo[i])
					zp_q[i][7:0] <= bus_i.dout;
				if (sel_hi[i])
					zp_q[i][15:8] <= bus_i.dout;
			end
		end
	end

	assign hit_o = !rom_access_i && ((|sel_lo) || (|sel_hi));

	always_comb begin
		ovl_o = ZP_MISS;
		for (int i = 0; i < 4; i++) begin
			if (sel_lo[i])
				ovl_o = zp_q[i][7:0];
			if (sel_hi[i])
				ovl_o = zp_q[i][15:8];
		end
	end

endmodule

`default_nettype wire
